//--- verilog.f
+incdir+source
source/cache_pkg.sv
source/tag_store.sv
source/line_store.sv
source/backing_memory.sv
source/cache_controller.sv
source/cache_top.sv
tb/cache_tb.sv

//--- Bender.yml
package:
  name: cache

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/cache_pkg.sv
      - source/tag_store.sv
      - source/line_store.sv
      - source/backing_memory.sv
      - source/cache_controller.sv
      - source/cache_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/cache_tb.sv

//--- tb/cache_tb.sv
`timescale 1ns/100ps
`include "cache_settings.svh"

module cache_tb;

  localparam int reset_cycles = 16;
  localparam int op_cycles    = 2 * `MEM_LATENCY + 6;  // dirty miss plus handshake
  localparam int total_ops    = 418;
  localparam int mem_words    = `MEM_LINES * `CACHE_LINE_WORDS;

  typedef struct packed {
    logic             write;
    cache_pkg::addr_t addr;
    cache_pkg::word_t data;   // expected read word
    logic             hit;
    logic [31:0]      cycle;  // cycle of the request strobe
  } expect_t;

  logic                 clk;
  logic                 reset;
  cache_pkg::cpu_req_t  cpu_req;
  logic                 ready;
  cache_pkg::cpu_resp_t cpu_resp;

  cache_pkg::word_t ref_mem [mem_words];       // flat word image of memory
  cache_pkg::tag_t  shadow_tag [`CACHE_SETS];
  logic             shadow_valid [`CACHE_SETS];
  expect_t          pending [$];
  int               issued;
  int               answered;
  int               checks_passed;
  int               checks_failed;
  logic [31:0]      cycle;

  cache_top dut (
    .clk      (clk),
    .reset    (reset),
    .cpu_req  (cpu_req),
    .ready    (ready),
    .cpu_resp (cpu_resp)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  always @(posedge clk) cycle <= cycle + 1;

  function automatic cache_pkg::word_t ref_read(cache_pkg::addr_t addr);
    return ref_mem[addr[$clog2(mem_words)+1:2]];
  endfunction

  // direct-mapped placement
  function automatic cache_pkg::index_t set_of(cache_pkg::addr_t addr);
    return cache_pkg::index_t'((addr >> `CACHE_OFFSET_BITS) % `CACHE_SETS);
  endfunction

  function automatic cache_pkg::tag_t tag_of(cache_pkg::addr_t addr);
    return cache_pkg::tag_t'(addr >> (`CACHE_OFFSET_BITS + `CACHE_INDEX_BITS));
  endfunction

  // called on a falling edge, returns on a falling edge
  task automatic run_op(input logic write, input cache_pkg::addr_t addr,
                        input cache_pkg::word_t data);
    expect_t e;
    int      waited;
    waited = 0;
    while (!ready && waited < 2 * op_cycles) begin
      @(negedge clk);
      waited++;
    end
    if (!ready) begin
      $display("ready stayed low before the request to address %h", addr);
      checks_failed++;
      return;
    end
    e.write = write;
    e.addr  = addr;
    e.data  = ref_read(addr);
    e.hit   = shadow_valid[set_of(addr)] && (shadow_tag[set_of(addr)] == tag_of(addr));
    e.cycle = cycle;
    pending.push_back(e);
    issued++;
    if (write) begin
      ref_mem[addr[$clog2(mem_words)+1:2]] = data;
    end
    shadow_valid[set_of(addr)] = 1'b1;  // allocate on every miss
    shadow_tag[set_of(addr)]   = tag_of(addr);
    cpu_req.valid = 1'b1;
    cpu_req.write = write;
    cpu_req.addr  = addr;
    cpu_req.wdata = data;
    @(negedge clk);
    cpu_req.valid = 1'b0;
    if (ready !== 1'b0) begin  // busy from the cycle after acceptance
      $display("error ready after request at %h: expected %h, got %h", addr, 1'b0, ready);
      checks_failed++;
    end else begin
      checks_passed++;
    end
    waited = 0;
    while (answered < issued && waited < 2 * op_cycles) begin
      @(posedge clk);
      waited++;
    end
    if (answered < issued) begin
      $display("no response to the %s at address %h", write ? "write" : "read", addr);
      checks_failed++;
      pending.delete();
      answered = issued;
    end
    @(negedge clk);
  endtask

  task automatic report_test(input int num, input string name, input int fails_before);
    if (checks_failed == fails_before) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d failed checks", num, name, checks_failed - fails_before);
    end
  endtask

  // compare every response against the oldest pending request
  always @(negedge clk) begin : compare
    expect_t e;
    if (!reset && cpu_resp.valid) begin
      if (pending.size() == 0) begin
        $display("response arrived with no request pending");
        checks_failed++;
      end else begin
        e = pending.pop_front();
        answered++;
        if (cpu_resp.hit !== e.hit) begin
          $display("error cpu_resp.hit at %h: expected %h, got %h", e.addr, e.hit, cpu_resp.hit);
          checks_failed++;
        end else begin
          checks_passed++;
        end
        if (!e.write) begin
          if (cpu_resp.rdata !== e.data) begin
            $display("error cpu_resp.rdata at %h: expected %h, got %h",
                     e.addr, e.data, cpu_resp.rdata);
            checks_failed++;
          end else begin
            checks_passed++;
          end
        end
        if (e.hit) begin
          if (cycle - e.cycle !== 32'd1) begin
            $display("error cpu_resp.valid cycles after request at %h: expected %h, got %h",
                     e.addr, 32'd1, cycle - e.cycle);
            checks_failed++;
          end else begin
            checks_passed++;
          end
        end
      end
    end
  end

  initial begin
    int               fails_before;
    logic             write;
    cache_pkg::addr_t addr;
    cache_pkg::word_t data;
    void'($urandom(32'h1546_b130));
    reset         = 1'b1;
    cpu_req       = '0;
    cycle         = '0;
    issued        = 0;
    answered      = 0;
    checks_passed = 0;
    checks_failed = 0;
    for (int i = 0; i < mem_words; i++) begin
      ref_mem[i] = '0;
    end
    for (int s = 0; s < `CACHE_SETS; s++) begin
      shadow_valid[s] = 1'b0;
      shadow_tag[s]   = '0;
    end
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    fails_before = checks_failed;
    repeat (8) begin  // idle while the monitor watches for stray responses
      @(negedge clk);
      if (ready !== 1'b1) begin
        $display("error ready: expected %h, got %h", 1'b1, ready);
        checks_failed++;
      end else begin
        checks_passed++;
      end
    end
    run_op(1'b0, 32'h0000_0000, '0);
    run_op(1'b0, 32'h0000_0034, '0);
    run_op(1'b0, 32'h0000_0098, '0);
    run_op(1'b0, 32'h0000_00fc, '0);
    report_test(1, "reset state and cold reads", fails_before);

    fails_before = checks_failed;
    run_op(1'b1, 32'h0000_0154, 32'hcafe_0154);
    run_op(1'b0, 32'h0000_0154, '0);  // hit in one cycle
    report_test(2, "write then read hit", fails_before);

    fails_before = checks_failed;
    run_op(1'b1, 32'h0000_02a8, 32'h1111_02a8);
    run_op(1'b1, 32'h0000_07a8, 32'h2222_07a8);  // same set evicts the dirty line
    run_op(1'b0, 32'h0000_02a8, '0);
    run_op(1'b0, 32'h0000_07a8, '0);
    report_test(3, "dirty eviction and refill", fails_before);

    fails_before = checks_failed;
    for (int w = 0; w < `CACHE_LINE_WORDS; w++) begin
      run_op(1'b1, 32'h0000_0360 + 4 * w, 32'h5a00_0000 + w);
    end
    for (int w = 0; w < `CACHE_LINE_WORDS; w++) begin
      run_op(1'b0, 32'h0000_0360 + 4 * w, '0);
    end
    report_test(4, "word merge within a line", fails_before);

    fails_before = checks_failed;
    for (int n = 0; n < 400; n++) begin
      write = ($urandom_range(1, 0) != 0);
      if ($urandom_range(1, 0)) begin
        addr = $urandom_range(255, 0) << 2;  // few tags give more hits
      end else begin
        addr = $urandom_range(mem_words - 1, 0) << 2;
      end
      data = $urandom;
      run_op(write, addr, data);
    end
    report_test(5, "random reads and writes", fails_before);

    $display("checks passed %0d, failed %0d", checks_passed, checks_failed);
    if (checks_failed == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // worst case per operation, plus reset and the idle window
  initial begin
    #((total_ops * op_cycles + reset_cycles + 64) * 40);
    $display("watchdog expired before the tests finished");
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- source/cache_top.sv
`timescale 1ns/100ps

module cache_top (
  input  logic                 clk,
  input  logic                 reset,
  input  cache_pkg::cpu_req_t  cpu_req,
  output logic                 ready,
  output cache_pkg::cpu_resp_t cpu_resp
);

  cache_pkg::index_t    index;
  cache_pkg::tag_t      lookup_tag;
  cache_pkg::word_sel_t word_sel;
  logic                 hit;
  logic                 victim_dirty;
  cache_pkg::tag_t      victim_tag;
  logic                 tag_we;
  logic                 new_dirty;
  logic                 word_we;
  logic                 fill_we;
  cache_pkg::word_t     wr_word;
  cache_pkg::word_t     rd_word;
  cache_pkg::line_t     victim_line;
  cache_pkg::mem_req_t  mem_req;
  logic                 mem_ready;
  cache_pkg::mem_resp_t mem_resp;

  cache_controller u_ctrl (
    .clk          (clk),
    .reset        (reset),
    .cpu_req      (cpu_req),
    .ready        (ready),
    .cpu_resp     (cpu_resp),
    .index        (index),
    .lookup_tag   (lookup_tag),
    .word_sel     (word_sel),
    .hit          (hit),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag),
    .tag_we       (tag_we),
    .new_dirty    (new_dirty),
    .word_we      (word_we),
    .fill_we      (fill_we),
    .wr_word      (wr_word),
    .rd_word      (rd_word),
    .victim_line  (victim_line),
    .mem_req      (mem_req),
    .mem_ready    (mem_ready),
    .mem_resp     (mem_resp)
  );

  tag_store u_tags (
    .clk          (clk),
    .reset        (reset),
    .index        (index),
    .lookup_tag   (lookup_tag),
    .tag_we       (tag_we),
    .new_dirty    (new_dirty),
    .hit          (hit),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag)
  );

  line_store u_lines (
    .clk         (clk),
    .index       (index),
    .word_sel    (word_sel),
    .word_we     (word_we),
    .wr_word     (wr_word),
    .fill_we     (fill_we),
    .fill_line   (mem_resp.rline),  // fill straight from memory
    .rd_word     (rd_word),
    .victim_line (victim_line)
  );

  backing_memory u_mem (
    .clk       (clk),
    .reset     (reset),
    .mem_req   (mem_req),
    .mem_ready (mem_ready),
    .mem_resp  (mem_resp)
  );

endmodule

//--- source/cache_controller.sv
`timescale 1ns/100ps
`include "cache_settings.svh"

module cache_controller (
  input  logic                  clk,
  input  logic                  reset,
  input  cache_pkg::cpu_req_t   cpu_req,
  output logic                  ready,
  output cache_pkg::cpu_resp_t  cpu_resp,
  output cache_pkg::index_t     index,
  output cache_pkg::tag_t       lookup_tag,
  output cache_pkg::word_sel_t  word_sel,
  input  logic                  hit,
  input  logic                  victim_dirty,
  input  cache_pkg::tag_t       victim_tag,
  output logic                  tag_we,
  output logic                  new_dirty,
  output logic                  word_we,
  output logic                  fill_we,
  output cache_pkg::word_t      wr_word,
  input  cache_pkg::word_t      rd_word,
  input  cache_pkg::line_t      victim_line,
  output cache_pkg::mem_req_t   mem_req,
  input  logic                  mem_ready,
  input  cache_pkg::mem_resp_t  mem_resp
);

  cache_pkg::cache_state_t state;
  cache_pkg::cache_state_t next_state;
  cache_pkg::cpu_req_t     req_q;      // accepted request
  logic                    missed;     // first lookup of this request missed
  logic                    rd_issued;  // fill read is outstanding

  // split the held address
  assign word_sel   = req_q.addr[`CACHE_OFFSET_BITS-1:2];
  assign index      = req_q.addr[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS];
  assign lookup_tag = req_q.addr[31 -: `CACHE_TAG_BITS];
  assign wr_word    = req_q.wdata;
  assign ready      = (state == cache_pkg::st_idle);

  always_comb begin
    next_state        = state;
    cpu_resp          = '0;
    cpu_resp.rdata    = rd_word;
    tag_we            = 1'b0;
    new_dirty         = 1'b0;
    word_we           = 1'b0;
    fill_we           = 1'b0;
    mem_req           = '0;
    mem_req.wline     = victim_line;
    mem_req.line_addr = req_q.addr[31:`CACHE_OFFSET_BITS];  // fill address
    case (state)
      cache_pkg::st_idle: begin
        if (cpu_req.valid) begin
          next_state = cache_pkg::st_compare_tag;
        end
      end
      cache_pkg::st_compare_tag: begin
        if (hit) begin
          cpu_resp.valid = 1'b1;
          cpu_resp.hit   = !missed;
          if (req_q.write) begin
            word_we   = 1'b1;
            tag_we    = 1'b1;
            new_dirty = 1'b1;
          end
          next_state = cache_pkg::st_idle;
        end else if (!victim_dirty) begin
          next_state = cache_pkg::st_allocate;  // clean or invalid victim
        end else begin
          // old line goes back to memory first
          mem_req.valid     = 1'b1;
          mem_req.write     = 1'b1;
          mem_req.line_addr = {victim_tag, index};
          next_state        = cache_pkg::st_write_back;
        end
      end
      cache_pkg::st_write_back: begin
        if (mem_resp.done) begin
          next_state = cache_pkg::st_allocate;
        end
      end
      cache_pkg::st_allocate: begin
        if (!rd_issued) begin
          mem_req.valid = 1'b1;
        end else if (mem_resp.done) begin
          fill_we    = 1'b1;
          tag_we     = 1'b1;  // new clean tag
          next_state = cache_pkg::st_compare_tag;
        end
      end
      default: next_state = cache_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= cache_pkg::st_idle;
      missed    <= 1'b0;
      rd_issued <= 1'b0;
    end else begin
      state <= next_state;
      if (state == cache_pkg::st_idle) begin
        missed <= 1'b0;
      end else if (state == cache_pkg::st_compare_tag && !hit) begin
        missed <= 1'b1;
      end
      if (mem_req.valid && !mem_req.write) begin
        rd_issued <= 1'b1;
      end else if (fill_we) begin
        rd_issued <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == cache_pkg::st_idle && cpu_req.valid) begin
      req_q <= cpu_req;
    end
  end

  // processor must wait for ready
  assert property (@(posedge clk) disable iff (reset) cpu_req.valid |-> ready);

  // sequencing keeps memory idle at every request
  assert property (@(posedge clk) disable iff (reset) mem_req.valid |-> mem_ready);

endmodule

//--- source/backing_memory.sv
`timescale 1ns/100ps
`include "cache_settings.svh"

module backing_memory (
  input  logic                 clk,
  input  logic                 reset,
  input  cache_pkg::mem_req_t  mem_req,
  output logic                 mem_ready,
  output cache_pkg::mem_resp_t mem_resp
);

  cache_pkg::line_t                   mem [`MEM_LINES];
  cache_pkg::mem_req_t                req_q;   // request in flight
  logic                               busy;
  logic [$clog2(`MEM_LATENCY+1)-1:0]  count;   // cycles left
  logic [$clog2(`MEM_LINES)-1:0]      slot;
  logic                               finish;  // last busy cycle
  logic                               done_q;
  cache_pkg::line_t                   rline_q;

  assign mem_ready = !busy;
  assign slot      = req_q.line_addr[$clog2(`MEM_LINES)-1:0];
  assign finish    = busy && (count == 1);

  assign mem_resp.done  = done_q;
  assign mem_resp.rline = rline_q;

  // latency counter
  always_ff @(posedge clk) begin
    if (reset) begin
      busy   <= 1'b0;
      count  <= '0;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (mem_req.valid && !busy) begin
        busy  <= 1'b1;
        count <= `MEM_LATENCY - 1;
      end else if (busy) begin
        count <= count - 1'b1;
        if (finish) begin
          busy   <= 1'b0;
          done_q <= 1'b1;  // done lands MEM_LATENCY after the strobe
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem_req.valid && !busy) begin
      req_q <= mem_req;
    end
  end

  // line array cleared on reset
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `MEM_LINES; i++) begin
        mem[i] <= '0;
      end
    end else if (finish && req_q.write) begin
      mem[slot] <= req_q.wline;
    end
  end

  always_ff @(posedge clk) begin
    if (finish) begin
      rline_q <= mem[slot];
    end
  end

  // one transfer at a time
  assert property (@(posedge clk) disable iff (reset) mem_req.valid |-> !busy);

  assert property (@(posedge clk) disable iff (reset)
    mem_req.valid |-> (mem_req.line_addr < `MEM_LINES));

endmodule

//--- source/line_store.sv
`timescale 1ns/100ps
`include "cache_settings.svh"

module line_store (
  input  logic                 clk,
  input  cache_pkg::index_t    index,
  input  cache_pkg::word_sel_t word_sel,
  input  logic                 word_we,
  input  cache_pkg::word_t     wr_word,
  input  logic                 fill_we,
  input  cache_pkg::line_t     fill_line,
  output cache_pkg::word_t     rd_word,
  output cache_pkg::line_t     victim_line
);

  cache_pkg::line_t lines [`CACHE_SETS];

  assign victim_line = lines[index];
  assign rd_word     = victim_line[word_sel*32 +: 32];  // word select

  always_ff @(posedge clk) begin
    if (fill_we) begin
      lines[index] <= fill_line;  // whole line from memory
    end else if (word_we) begin
      lines[index][word_sel*32 +: 32] <= wr_word;  // merge one word
    end
  end

  // fill and processor write come from different controller states
  assert property (@(posedge clk) word_we |-> !fill_we);

endmodule

//--- source/tag_store.sv
`timescale 1ns/100ps
`include "cache_settings.svh"

module tag_store (
  input  logic              clk,
  input  logic              reset,
  input  cache_pkg::index_t index,
  input  cache_pkg::tag_t   lookup_tag,
  input  logic              tag_we,
  input  logic              new_dirty,
  output logic              hit,
  output logic              victim_dirty,
  output cache_pkg::tag_t   victim_tag
);

  cache_pkg::tag_t         tags [`CACHE_SETS];
  logic [`CACHE_SETS-1:0]  valid;
  logic [`CACHE_SETS-1:0]  dirty;

  // combinational lookup of the indexed set
  assign victim_tag   = tags[index];
  assign victim_dirty = dirty[index];
  assign hit          = valid[index] && (tags[index] == lookup_tag);

  always_ff @(posedge clk) begin
    if (tag_we) begin
      tags[index] <= lookup_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
      dirty <= '0;
    end else if (tag_we) begin
      valid[index] <= 1'b1;
      dirty[index] <= new_dirty;
    end
  end

  // write-back relies on dirty implying valid
  assert property (@(posedge clk) disable iff (reset) (dirty & ~valid) == '0);

endmodule

//--- source/cache_pkg.sv
`include "cache_settings.svh"

package cache_pkg;

  typedef logic [31:0]                         word_t;
  typedef logic [31:0]                         addr_t;
  typedef logic [`CACHE_TAG_BITS-1:0]          tag_t;
  typedef logic [`CACHE_INDEX_BITS-1:0]        index_t;
  typedef logic [`CACHE_OFFSET_BITS-3:0]       word_sel_t;  // word within line
  typedef logic [`CACHE_LINE_WORDS*32-1:0]     line_t;
  typedef logic [31-`CACHE_OFFSET_BITS:0]      line_addr_t; // byte addr >> offset

  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    word_t wdata;
  } cpu_req_t;

  typedef struct packed {
    logic  valid;
    logic  hit;
    word_t rdata;
  } cpu_resp_t;

  typedef struct packed {
    logic       valid;
    logic       write;
    line_addr_t line_addr;
    line_t      wline;
  } mem_req_t;

  typedef struct packed {
    logic  done;
    line_t rline;
  } mem_resp_t;

  typedef enum logic [1:0] {
    st_idle,
    st_compare_tag,
    st_write_back,
    st_allocate
  } cache_state_t;

endpackage

//--- source/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// cache geometry
`define CACHE_SETS        16
`define CACHE_INDEX_BITS  4
`define CACHE_LINE_WORDS  4
`define CACHE_OFFSET_BITS 4   // byte offset within a line
`define CACHE_TAG_BITS    24

// backing memory
`define MEM_LINES         256
`define MEM_LATENCY       6   // request strobe to done strobe

`endif
